//--- decode_execute.f
common/diaosi_types_pkg.sv
decode/instr_decoder.sv
rtl/dc_ex.sv
execute/execute_unit.sv
rtl/decode_execute.sv
testbench/decode_execute_assertions.sv
testbench/decode_execute_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the decode/execute testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module decode_execute_tb -f decode_execute.f \
  || { echo "Verilator build failed."; exit 1; }
sim_out="$(./obj_dir/Vdecode_execute_tb 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -q "Result: PASSED" \
  && echo "Simulation passed." \
  || { echo "Simulation did not pass."; exit 1; }

//--- testbench/decode_execute_tb.sv
`timescale 1ns/1ps
// Testbench for the decode-to-execute slice.
// Table of instructions with a reference model of the expected outputs,
// applied one row per clock, with a cycle limit and a closing summary.
module decode_execute_tb;

  localparam int MAX_ROWS = 32;
  localparam logic [31:0] LFSR_SEED = 32'h0f7a9a24;

  typedef struct packed {
    logic [31:0] result;
    logic        chk_result;
    logic        wen;
    logic [4:0]  wsel;
    logic        d_ren;
    logic        d_wen;
    logic [31:0] store_data;
    logic [31:0] next_pc;
    logic        redirect;
    logic        halt;
  } expect_t;

  logic        CLK;
  logic        nRST;
  logic [31:0] instr;
  logic [31:0] npc;
  logic [31:0] rdat1;
  logic [31:0] rdat2;
  logic        flush;
  logic        en;
  logic [31:0] result;
  logic        wen;
  logic [4:0]  wsel;
  logic        d_ren;
  logic        d_wen;
  logic [31:0] store_data;
  logic [31:0] next_pc;
  logic        redirect;
  logic        halt;

  logic [31:0] row_instr [MAX_ROWS];
  logic [31:0] row_npc   [MAX_ROWS];
  logic [31:0] row_rdat1 [MAX_ROWS];
  logic [31:0] row_rdat2 [MAX_ROWS];
  logic        row_flush [MAX_ROWS];
  logic        row_en    [MAX_ROWS];
  string       row_name  [MAX_ROWS];
  expect_t     exp_tab   [MAX_ROWS];
  int          n_rows;
  logic [31:0] lfsr_state;
  int          cycle_count;
  int          row_errors;
  int          passed_tests;
  int          failed_tests;

  decode_execute i_decode_execute (.*);

  always #5 CLK = ~CLK;

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= n_rows + 20) begin
      $display("Timeout: the run went past %0d clock cycles.", n_rows + 20);
      $display("Result: FAILED");
      $finish;
    end
  end

  // **************************************************
  // Random operands and instruction words.
  // **************************************************
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] w;
    w = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[30:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic logic [31:0] rtype_word(input logic [5:0] fn, input logic [4:0] sh);
    return {6'h00, 5'(random_bits(5)), 5'(random_bits(5)), 5'(random_bits(5)), sh, fn};
  endfunction

  function automatic logic [31:0] imm_word(input logic [5:0] op, input logic [15:0] imm);
    return {op, 5'(random_bits(5)), 5'(random_bits(5)), imm};
  endfunction

  function automatic logic [31:0] jump_word(input logic [5:0] op);
    return {op, 26'(random_bits(26))};
  endfunction

  // **************************************************
  // Reference model.
  // **************************************************
  function automatic expect_t bubble_outputs();
    expect_t e;
    e = '0;
    e.chk_result = 1'b1;
    return e;
  endfunction

  function automatic expect_t model_row(input logic [31:0] iw, input logic [31:0] pc4,
                                        input logic [31:0] a, input logic [31:0] b);
    expect_t     e;
    logic [15:0] imm;
    logic [31:0] sext;
    logic [31:0] zext;
    imm  = iw[15:0];
    sext = {{16{imm[15]}}, imm};
    zext = {16'h0000, imm};
    e = '0;
    e.store_data = b;
    e.next_pc    = pc4;
    e.chk_result = 1'b1;
    e.wen        = 1'b1;
    e.wsel       = iw[20:16];
    case (iw[31:26])
      6'h00: begin
        e.wsel = iw[15:11];
        case (iw[5:0])
          6'h21: e.result = a + b;
          6'h23: e.result = a - b;
          6'h24: e.result = a & b;
          6'h25: e.result = a | b;
          6'h26: e.result = a ^ b;
          6'h2A: e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          6'h00: e.result = a << iw[10:6];
          default: e.result = a >> iw[10:6];
        endcase
      end
      6'h09: e.result = a + sext;
      6'h0C: e.result = a & zext;
      6'h0D: e.result = a | zext;
      6'h0F: e.result = {imm, 16'h0000};
      6'h23: begin
        e.result = a + sext;
        e.d_ren  = 1'b1;
      end
      6'h2B: begin
        e.result = a + sext;
        e.d_wen  = 1'b1;
        e.wen    = 1'b0;
        e.wsel   = '0;
      end
      default: begin
        // Branches, jumps and HALT write no register.
        e.chk_result = 1'b0;
        e.wen        = 1'b0;
        e.wsel       = '0;
        if ((iw[31:26] == 6'h04 && a == b) || (iw[31:26] == 6'h05 && a != b)) begin
          e.redirect = 1'b1;
          e.next_pc  = pc4 + (sext << 2);
        end else if (iw[31:26] == 6'h02) begin
          e.redirect = 1'b1;
          e.next_pc  = {pc4[31:28], iw[25:0], 2'b00};
        end else if (iw[31:26] == diaosi_types_pkg::HALT_OPCODE) begin
          e.halt = 1'b1;
        end
      end
    endcase
    return e;
  endfunction

  // **************************************************
  // Stimulus table.
  // **************************************************
  task automatic add_row(input string name, input logic [31:0] iw, input logic [31:0] a,
                         input logic [31:0] b, input logic fl, input logic enable);
    row_name[n_rows]  = name;
    row_instr[n_rows] = iw;
    row_npc[n_rows]   = random_bits(32);
    row_rdat1[n_rows] = a;
    row_rdat2[n_rows] = b;
    row_flush[n_rows] = fl;
    row_en[n_rows]    = enable;
    n_rows++;
  endtask

  task automatic build_table();
    logic [31:0] same;
    add_row("addu", rtype_word(6'h21, 5'd0), random_bits(32), random_bits(32), 1'b0, 1'b1);
    add_row("subu", rtype_word(6'h23, 5'd0), random_bits(32), random_bits(32), 1'b0, 1'b1);
    add_row("and", rtype_word(6'h24, 5'd0), random_bits(32), random_bits(32), 1'b0, 1'b1);
    add_row("or", rtype_word(6'h25, 5'd0), random_bits(32), random_bits(32), 1'b0, 1'b1);
    add_row("xor", rtype_word(6'h26, 5'd0), random_bits(32), random_bits(32), 1'b0, 1'b1);
    add_row("slt_neg", rtype_word(6'h2A, 5'd0), 32'hFFFF_FFFB, 32'd3, 1'b0, 1'b1);
    add_row("slt_pos", rtype_word(6'h2A, 5'd0), 32'd3, 32'hFFFF_FFFB, 1'b0, 1'b1);
    add_row("sll", rtype_word(6'h00, 5'd7), random_bits(32), random_bits(32), 1'b0, 1'b1);
    add_row("srl", rtype_word(6'h02, 5'd13), random_bits(32), random_bits(32), 1'b0, 1'b1);
    add_row("addiu", imm_word(6'h09, 16'hFFF0), random_bits(32), random_bits(32), 1'b0, 1'b1);
    add_row("andi", imm_word(6'h0C, 16'h8F0F), random_bits(32), random_bits(32), 1'b0, 1'b1);
    add_row("ori", imm_word(6'h0D, 16'hA5A5), random_bits(32), random_bits(32), 1'b0, 1'b1);
    add_row("lui", imm_word(6'h0F, 16'h1234), random_bits(32), random_bits(32), 1'b0, 1'b1);
    add_row("lw", imm_word(6'h23, 16'hFFFC), random_bits(32), random_bits(32), 1'b0, 1'b1);
    add_row("sw", imm_word(6'h2B, 16'h0040), random_bits(32), random_bits(32), 1'b0, 1'b1);
    same = random_bits(32);
    add_row("beq_taken", imm_word(6'h04, 16'hFFF8), same, same, 1'b0, 1'b1);
    add_row("beq_not", imm_word(6'h04, 16'h0010), same, same ^ 32'h1, 1'b0, 1'b1);
    add_row("bne_taken", imm_word(6'h05, 16'h0021), same, ~same, 1'b0, 1'b1);
    add_row("bne_not", imm_word(6'h05, 16'hFF00), same, same, 1'b0, 1'b1);
    add_row("j", jump_word(6'h02), random_bits(32), random_bits(32), 1'b0, 1'b1);
    add_row("halt", jump_word(diaosi_types_pkg::HALT_OPCODE), same, same, 1'b0, 1'b1);
    add_row("addu_2", rtype_word(6'h21, 5'd0), random_bits(32), random_bits(32), 1'b0, 1'b1);
    add_row("hold_1", rtype_word(6'h21, 5'd0), random_bits(32), random_bits(32), 1'b0, 1'b0);
    add_row("hold_2", imm_word(6'h23, 16'h0004), random_bits(32), random_bits(32), 1'b0, 1'b0);
    add_row("flush", imm_word(6'h23, 16'h0008), random_bits(32), random_bits(32), 1'b1, 1'b1);
    add_row("sw_2", imm_word(6'h2B, 16'hFF80), random_bits(32), random_bits(32), 1'b0, 1'b1);
    // Expected outputs, with hold rows repeating the row before them.
    for (int i = 0; i < n_rows; i++) begin
      if (row_flush[i]) begin
        exp_tab[i] = bubble_outputs();
      end else if (!row_en[i]) begin
        exp_tab[i] = (i == 0) ? bubble_outputs() : exp_tab[i-1];
      end else begin
        exp_tab[i] = model_row(row_instr[i], row_npc[i], row_rdat1[i], row_rdat2[i]);
      end
    end
  endtask

  task automatic apply_row(input int i);
    instr = row_instr[i];
    npc   = row_npc[i];
    rdat1 = row_rdat1[i];
    rdat2 = row_rdat2[i];
    flush = row_flush[i];
    en    = row_en[i];
  endtask

  // **************************************************
  // Output checks.
  // **************************************************
  task automatic compare_field(input string sig, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, sig, got, want);
      row_errors++;
    end
  endtask

  task automatic check_outputs(input string name, input expect_t e);
    row_errors = 0;
    if (e.chk_result) begin
      compare_field("result", result, e.result);
    end
    compare_field("wen", {31'b0, wen}, {31'b0, e.wen});
    compare_field("wsel", {27'b0, wsel}, {27'b0, e.wsel});
    compare_field("d_ren", {31'b0, d_ren}, {31'b0, e.d_ren});
    compare_field("d_wen", {31'b0, d_wen}, {31'b0, e.d_wen});
    compare_field("store_data", store_data, e.store_data);
    compare_field("next_pc", next_pc, e.next_pc);
    compare_field("redirect", {31'b0, redirect}, {31'b0, e.redirect});
    compare_field("halt", {31'b0, halt}, {31'b0, e.halt});
    if (row_errors == 0) begin
      passed_tests++;
      $display("pass  %s", name);
    end else begin
      failed_tests++;
      $display("fail  %s with %0d wrong outputs", name, row_errors);
    end
  endtask

  initial begin
    CLK          = 1'b0;
    nRST         = 1'b0;
    instr        = '0;
    npc          = '0;
    rdat1        = '0;
    rdat2        = '0;
    flush        = 1'b0;
    en           = 1'b0;
    n_rows       = 0;
    cycle_count  = 0;
    passed_tests = 0;
    failed_tests = 0;
    lfsr_state   = LFSR_SEED;
    build_table();
    repeat (4) @(posedge CLK);
    #1;
    nRST = 1'b1;
    check_outputs("reset", bubble_outputs());
    // Each row is checked one edge after it is driven.
    for (int i = 0; i < n_rows; i++) begin
      @(posedge CLK);
      #1;
      if (i > 0) begin
        check_outputs(row_name[i-1], exp_tab[i-1]);
      end
      apply_row(i);
    end
    @(posedge CLK);
    #1;
    check_outputs(row_name[n_rows-1], exp_tab[n_rows-1]);
    $display("%0d tests, %0d passed, %0d failed", passed_tests + failed_tests,
             passed_tests, failed_tests);
    if (failed_tests == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/decode_execute_assertions.sv
`timescale 1ns/1ps
// Concurrent checks on the dc_ex pipeline register.
// Flush clears the control fields, a hold keeps the outputs, and a load
// never coincides with a store.
module decode_execute_assertions (
  input logic                                    CLK,
  input logic                                    nRST,
  input logic                                    flush,
  input logic                                    en,
  input logic                                    wen_o2,
  input logic                                    d_ren_o2,
  input logic                                    d_wen_o2,
  input logic                                    halt_o2,
  input logic [diaosi_types_pkg::WORD_W-1:0]     npc_o2,
  input logic [diaosi_types_pkg::WORD_W-1:0]     ext32_o2,
  input logic [diaosi_types_pkg::WORD_W-1:0]     rdat1_o2,
  input logic [diaosi_types_pkg::WORD_W-1:0]     rdat2_o2,
  input logic [diaosi_types_pkg::REG_ADDR_W-1:0] wsel_o2
);

  flush_clears_controls: assert property (@(posedge CLK) disable iff (!nRST)
    flush |=> (!wen_o2 && !d_ren_o2 && !d_wen_o2 && !halt_o2))
    else $error("dc_ex control fields not cleared after a flush");

  // Data and control fields both stay put while the stage is stalled.
  hold_keeps_outputs: assert property (@(posedge CLK) disable iff (!nRST)
    (!flush && !en) |=> ($stable({npc_o2, ext32_o2, rdat1_o2, rdat2_o2}) &&
                         $stable({wsel_o2, wen_o2, d_ren_o2, d_wen_o2, halt_o2})))
    else $error("dc_ex outputs changed while en was low");

  load_store_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
    !(d_ren_o2 && d_wen_o2))
    else $error("dc_ex has d_ren_o2 and d_wen_o2 high together");

endmodule

bind dc_ex decode_execute_assertions i_decode_execute_assertions (.*);

//--- rtl/decode_execute.sv
`timescale 1ns/1ps
// Decode-to-execute slice.
// Decoder, dc_ex pipeline register and execute unit.
module decode_execute (
  input  logic                                    CLK,
  input  logic                                    nRST,
  input  logic [diaosi_types_pkg::WORD_W-1:0]     instr,
  input  logic [diaosi_types_pkg::WORD_W-1:0]     npc,
  input  logic [diaosi_types_pkg::WORD_W-1:0]     rdat1,
  input  logic [diaosi_types_pkg::WORD_W-1:0]     rdat2,
  input  logic                                    flush,
  input  logic                                    en,
  output logic [diaosi_types_pkg::WORD_W-1:0]     result,
  output logic                                    wen,
  output logic [diaosi_types_pkg::REG_ADDR_W-1:0] wsel,
  output logic                                    d_ren,
  output logic                                    d_wen,
  output logic [diaosi_types_pkg::WORD_W-1:0]     store_data,
  output logic [diaosi_types_pkg::WORD_W-1:0]     next_pc,
  output logic                                    redirect,
  output logic                                    halt
);

  // Decode stage fields.
  logic [diaosi_types_pkg::WORD_W-1:0]     npc_d, ext32_d, lui_d;
  logic [25:0]                             j_addr26_d;
  logic [15:0]                             imm16_d;
  logic [4:0]                              shamt_d;
  logic                                    halt_d, d_ren_d, d_wen_d, wen_d;
  logic [diaosi_types_pkg::REG_ADDR_W-1:0] wsel_d, rsel1_d, rsel2_d;
  diaosi_types_pkg::zerosel_t              zero_sel_d;
  diaosi_types_pkg::pcsrc_t                pc_src_d;
  diaosi_types_pkg::alusrc_t               alu_src_d;
  diaosi_types_pkg::wmux_t                 w_mux_d;
  diaosi_types_pkg::aluop_t                alu_op_d;

  // Execute stage fields. rsel1_o2 and rsel2_o2 are kept for a later forwarding unit.
  logic [diaosi_types_pkg::WORD_W-1:0]     npc_o2, ext32_o2, lui_o2, rdat1_o2, rdat2_o2;
  logic [25:0]                             j_addr26_o2;
  logic [15:0]                             imm16_o2;
  logic [4:0]                              shamt_o2;
  logic                                    halt_o2, d_ren_o2, d_wen_o2, wen_o2;
  logic [diaosi_types_pkg::REG_ADDR_W-1:0] wsel_o2, rsel1_o2, rsel2_o2;
  diaosi_types_pkg::zerosel_t              zero_sel_o2;
  diaosi_types_pkg::pcsrc_t                pc_src_o2;
  diaosi_types_pkg::alusrc_t               alu_src_o2;
  diaosi_types_pkg::wmux_t                 w_mux_o2;
  diaosi_types_pkg::aluop_t                alu_op_o2;

  instr_decoder i_instr_decoder (.*);

  dc_ex i_dc_ex (
    .CLK         (CLK),
    .nRST        (nRST),
    .flush       (flush),
    .en          (en),
    .npc_i2      (npc_d),
    .ext32_i2    (ext32_d),
    .lui_i2      (lui_d),
    .rdat1_i2    (rdat1),
    .rdat2_i2    (rdat2),
    .j_addr26_i2 (j_addr26_d),
    .imm16_i2    (imm16_d),
    .shamt_i2    (shamt_d),
    .halt_i2     (halt_d),
    .d_ren_i2    (d_ren_d),
    .d_wen_i2    (d_wen_d),
    .wen_i2      (wen_d),
    .wsel_i2     (wsel_d),
    .rsel1_i2    (rsel1_d),
    .rsel2_i2    (rsel2_d),
    .zero_sel_i2 (zero_sel_d),
    .pc_src_i2   (pc_src_d),
    .alu_src_i2  (alu_src_d),
    .w_mux_i2    (w_mux_d),
    .alu_op_i2   (alu_op_d),
    .npc_o2      (npc_o2),
    .ext32_o2    (ext32_o2),
    .lui_o2      (lui_o2),
    .rdat1_o2    (rdat1_o2),
    .rdat2_o2    (rdat2_o2),
    .j_addr26_o2 (j_addr26_o2),
    .imm16_o2    (imm16_o2),
    .shamt_o2    (shamt_o2),
    .halt_o2     (halt_o2),
    .d_ren_o2    (d_ren_o2),
    .d_wen_o2    (d_wen_o2),
    .wen_o2      (wen_o2),
    .wsel_o2     (wsel_o2),
    .rsel1_o2    (rsel1_o2),
    .rsel2_o2    (rsel2_o2),
    .zero_sel_o2 (zero_sel_o2),
    .pc_src_o2   (pc_src_o2),
    .alu_src_o2  (alu_src_o2),
    .w_mux_o2    (w_mux_o2),
    .alu_op_o2   (alu_op_o2)
  );

  execute_unit i_execute_unit (.*);

endmodule

//--- execute/execute_unit.sv
`timescale 1ns/1ps
// Execute stage.
// ALU with operand select, write-back select, branch and jump resolution.
module execute_unit (
  input  logic [diaosi_types_pkg::WORD_W-1:0]     npc_o2,
  input  logic [diaosi_types_pkg::WORD_W-1:0]     ext32_o2,
  input  logic [25:0]                             j_addr26_o2,
  input  logic [15:0]                             imm16_o2,
  input  logic [diaosi_types_pkg::WORD_W-1:0]     lui_o2,
  input  diaosi_types_pkg::zerosel_t              zero_sel_o2,
  input  diaosi_types_pkg::pcsrc_t                pc_src_o2,
  input  diaosi_types_pkg::alusrc_t               alu_src_o2,
  input  diaosi_types_pkg::wmux_t                 w_mux_o2,
  input  logic [4:0]                              shamt_o2,
  input  logic                                    halt_o2,
  input  logic                                    d_ren_o2,
  input  logic                                    d_wen_o2,
  input  logic                                    wen_o2,
  input  logic [diaosi_types_pkg::REG_ADDR_W-1:0] wsel_o2,
  input  diaosi_types_pkg::aluop_t                alu_op_o2,
  input  logic [diaosi_types_pkg::WORD_W-1:0]     rdat1_o2,
  input  logic [diaosi_types_pkg::WORD_W-1:0]     rdat2_o2,
  output logic [diaosi_types_pkg::WORD_W-1:0]     result,
  output logic                                    wen,
  output logic [diaosi_types_pkg::REG_ADDR_W-1:0] wsel,
  output logic                                    d_ren,
  output logic                                    d_wen,
  output logic [diaosi_types_pkg::WORD_W-1:0]     store_data,
  output logic [diaosi_types_pkg::WORD_W-1:0]     next_pc,
  output logic                                    redirect,
  output logic                                    halt
);

  localparam int W = diaosi_types_pkg::WORD_W;

  logic [W-1:0] op_b;
  logic [W-1:0] alu_out;
  logic [W-1:0] branch_tgt;
  logic [W-1:0] jump_tgt;
  logic         taken;

  always_comb begin
    case (alu_src_o2)
      diaosi_types_pkg::EXT32_DIAOSI: op_b = ext32_o2;
      diaosi_types_pkg::SHAMT_DIAOSI: op_b = {{(W-5){1'b0}}, shamt_o2};
      default:                        op_b = rdat2_o2;
    endcase
  end

  // **************************************************
  // ALU.
  // **************************************************
  always_comb begin
    case (alu_op_o2)
      diaosi_types_pkg::ALU_SLL: alu_out = rdat1_o2 << op_b[4:0];
      diaosi_types_pkg::ALU_SRL: alu_out = rdat1_o2 >> op_b[4:0];
      diaosi_types_pkg::ALU_ADD: alu_out = rdat1_o2 + op_b;
      diaosi_types_pkg::ALU_SUB: alu_out = rdat1_o2 - op_b;
      diaosi_types_pkg::ALU_AND: alu_out = rdat1_o2 & op_b;
      diaosi_types_pkg::ALU_OR:  alu_out = rdat1_o2 | op_b;
      diaosi_types_pkg::ALU_XOR: alu_out = rdat1_o2 ^ op_b;
      diaosi_types_pkg::ALU_SLT: alu_out = {{(W-1){1'b0}}, $signed(rdat1_o2) < $signed(op_b)};
      default:                   alu_out = '0;
    endcase
  end

  assign result     = (w_mux_o2 == diaosi_types_pkg::ALU_DIAOSI) ? alu_out : lui_o2;
  assign store_data = rdat2_o2;
  assign wen        = wen_o2;
  assign wsel       = wsel_o2;
  assign d_ren      = d_ren_o2;
  assign d_wen      = d_wen_o2;
  assign halt       = halt_o2;

  // **************************************************
  // Next PC.
  // **************************************************
  assign taken = (zero_sel_o2 == diaosi_types_pkg::BEQ_DIAOSI) ? (rdat1_o2 == rdat2_o2)
                                                               : (rdat1_o2 != rdat2_o2);
  // Word offset from the sign-extended immediate
  assign branch_tgt = npc_o2 + {{(W-18){imm16_o2[15]}}, imm16_o2, 2'b00};
  assign jump_tgt   = {npc_o2[W-1:W-4], j_addr26_o2, 2'b00};

  assign redirect = (pc_src_o2 == diaosi_types_pkg::JUMP_DIAOSI) ||
                    ((pc_src_o2 == diaosi_types_pkg::BRANCH_DIAOSI) && taken);
  assign next_pc  = !redirect ? npc_o2 :
                    (pc_src_o2 == diaosi_types_pkg::JUMP_DIAOSI) ? jump_tgt : branch_tgt;

endmodule

//--- rtl/dc_ex.sv
`timescale 1ns/1ps
// Decode/execute pipeline register.
// Flush loads a bubble, a low enable holds, otherwise the fields are captured.
module dc_ex (
  input  logic                                    CLK,
  input  logic                                    nRST,
  input  logic                                    flush,
  input  logic                                    en,
  input  logic [diaosi_types_pkg::WORD_W-1:0]     npc_i2, ext32_i2, lui_i2, rdat1_i2, rdat2_i2,
  input  logic [25:0]                             j_addr26_i2,
  input  logic [15:0]                             imm16_i2,
  input  logic [4:0]                              shamt_i2,
  input  logic                                    halt_i2, d_ren_i2, d_wen_i2, wen_i2,
  input  logic [diaosi_types_pkg::REG_ADDR_W-1:0] wsel_i2, rsel1_i2, rsel2_i2,
  input  diaosi_types_pkg::zerosel_t              zero_sel_i2,
  input  diaosi_types_pkg::pcsrc_t                pc_src_i2,
  input  diaosi_types_pkg::alusrc_t               alu_src_i2,
  input  diaosi_types_pkg::wmux_t                 w_mux_i2,
  input  diaosi_types_pkg::aluop_t                alu_op_i2,
  output logic [diaosi_types_pkg::WORD_W-1:0]     npc_o2, ext32_o2, lui_o2, rdat1_o2, rdat2_o2,
  output logic [25:0]                             j_addr26_o2,
  output logic [15:0]                             imm16_o2,
  output logic [4:0]                              shamt_o2,
  output logic                                    halt_o2, d_ren_o2, d_wen_o2, wen_o2,
  output logic [diaosi_types_pkg::REG_ADDR_W-1:0] wsel_o2, rsel1_o2, rsel2_o2,
  output diaosi_types_pkg::zerosel_t              zero_sel_o2,
  output diaosi_types_pkg::pcsrc_t                pc_src_o2,
  output diaosi_types_pkg::alusrc_t               alu_src_o2,
  output diaosi_types_pkg::wmux_t                 w_mux_o2,
  output diaosi_types_pkg::aluop_t                alu_op_o2
);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      npc_o2      <= '0;
      ext32_o2    <= '0;
      j_addr26_o2 <= '0;
      imm16_o2    <= '0;
      lui_o2      <= '0;
      zero_sel_o2 <= diaosi_types_pkg::BEQ_DIAOSI;
      pc_src_o2   <= diaosi_types_pkg::ADD4_DIAOSI;
      alu_src_o2  <= diaosi_types_pkg::RDAT2_DIAOSI;
      w_mux_o2    <= diaosi_types_pkg::LUI_DIAOSI;
      shamt_o2    <= '0;
      halt_o2     <= 1'b0;
      d_ren_o2    <= 1'b0;
      d_wen_o2    <= 1'b0;
      wen_o2      <= 1'b0;
      wsel_o2     <= '0;
      alu_op_o2   <= diaosi_types_pkg::ALU_SLL;
      rdat1_o2    <= '0;
      rdat2_o2    <= '0;
      rsel1_o2    <= '0;
      rsel2_o2    <= '0;
    end else if (flush) begin
      // Same bubble as reset.
      npc_o2      <= '0;
      ext32_o2    <= '0;
      j_addr26_o2 <= '0;
      imm16_o2    <= '0;
      lui_o2      <= '0;
      zero_sel_o2 <= diaosi_types_pkg::BEQ_DIAOSI;
      pc_src_o2   <= diaosi_types_pkg::ADD4_DIAOSI;
      alu_src_o2  <= diaosi_types_pkg::RDAT2_DIAOSI;
      w_mux_o2    <= diaosi_types_pkg::LUI_DIAOSI;
      shamt_o2    <= '0;
      halt_o2     <= 1'b0;
      d_ren_o2    <= 1'b0;
      d_wen_o2    <= 1'b0;
      wen_o2      <= 1'b0;
      wsel_o2     <= '0;
      alu_op_o2   <= diaosi_types_pkg::ALU_SLL;
      rdat1_o2    <= '0;
      rdat2_o2    <= '0;
      rsel1_o2    <= '0;
      rsel2_o2    <= '0;
    end else if (en) begin
      npc_o2      <= npc_i2;
      ext32_o2    <= ext32_i2;
      j_addr26_o2 <= j_addr26_i2;
      imm16_o2    <= imm16_i2;
      lui_o2      <= lui_i2;
      zero_sel_o2 <= zero_sel_i2;
      pc_src_o2   <= pc_src_i2;
      alu_src_o2  <= alu_src_i2;
      w_mux_o2    <= w_mux_i2;
      shamt_o2    <= shamt_i2;
      halt_o2     <= halt_i2;
      d_ren_o2    <= d_ren_i2;
      d_wen_o2    <= d_wen_i2;
      wen_o2      <= wen_i2;
      wsel_o2     <= wsel_i2;
      alu_op_o2   <= alu_op_i2;
      rdat1_o2    <= rdat1_i2;
      rdat2_o2    <= rdat2_i2;
      rsel1_o2    <= rsel1_i2;
      rsel2_o2    <= rsel2_i2;
    end
  end

endmodule

//--- decode/instr_decoder.sv
`timescale 1ns/1ps
// Instruction decoder for the MIPS subset.
// Splits the word into its fields and derives the control signals.
module instr_decoder (
  input  logic [diaosi_types_pkg::WORD_W-1:0]     instr,
  input  logic [diaosi_types_pkg::WORD_W-1:0]     npc,
  output logic [diaosi_types_pkg::WORD_W-1:0]     npc_d,
  output logic [diaosi_types_pkg::WORD_W-1:0]     ext32_d,
  output logic [25:0]                             j_addr26_d,
  output logic [15:0]                             imm16_d,
  output logic [diaosi_types_pkg::WORD_W-1:0]     lui_d,
  output diaosi_types_pkg::zerosel_t              zero_sel_d,
  output diaosi_types_pkg::pcsrc_t                pc_src_d,
  output diaosi_types_pkg::alusrc_t               alu_src_d,
  output diaosi_types_pkg::wmux_t                 w_mux_d,
  output logic [4:0]                              shamt_d,
  output logic                                    halt_d,
  output logic                                    d_ren_d,
  output logic                                    d_wen_d,
  output logic                                    wen_d,
  output logic [diaosi_types_pkg::REG_ADDR_W-1:0] wsel_d,
  output diaosi_types_pkg::aluop_t                alu_op_d,
  output logic [diaosi_types_pkg::REG_ADDR_W-1:0] rsel1_d,
  output logic [diaosi_types_pkg::REG_ADDR_W-1:0] rsel2_d
);

  diaosi_types_pkg::opcode_t               opcode;
  diaosi_types_pkg::funct_t                funct;
  logic [diaosi_types_pkg::REG_ADDR_W-1:0] rt;
  logic [diaosi_types_pkg::REG_ADDR_W-1:0] rd;
  logic                                    zero_ext;

  assign opcode     = diaosi_types_pkg::opcode_t'(instr[31:26]);
  assign funct      = diaosi_types_pkg::funct_t'(instr[5:0]);
  assign rt         = instr[20:16];
  assign rd         = instr[15:11];
  assign rsel1_d    = instr[25:21];
  assign rsel2_d    = rt;
  assign shamt_d    = instr[10:6];
  assign imm16_d    = instr[15:0];
  assign j_addr26_d = instr[25:0];
  assign npc_d      = npc;
  assign lui_d      = {imm16_d, 16'h0000};

  // Logical immediates are zero extended.
  assign zero_ext = (opcode == diaosi_types_pkg::ANDI) || (opcode == diaosi_types_pkg::ORI);
  assign ext32_d  = zero_ext ? {16'h0000, imm16_d} : {{16{imm16_d[15]}}, imm16_d};

  always_comb begin
    // Start from a bubble.
    zero_sel_d = diaosi_types_pkg::BEQ_DIAOSI;
    pc_src_d   = diaosi_types_pkg::ADD4_DIAOSI;
    alu_src_d  = diaosi_types_pkg::RDAT2_DIAOSI;
    w_mux_d    = diaosi_types_pkg::LUI_DIAOSI;
    alu_op_d   = diaosi_types_pkg::ALU_SLL;
    halt_d     = 1'b0;
    d_ren_d    = 1'b0;
    d_wen_d    = 1'b0;
    wen_d      = 1'b0;
    wsel_d     = '0;
    case (opcode)
      diaosi_types_pkg::RTYPE: begin
        wen_d   = 1'b1;
        wsel_d  = rd;
        w_mux_d = diaosi_types_pkg::ALU_DIAOSI;
        case (funct)
          diaosi_types_pkg::ADDU: alu_op_d = diaosi_types_pkg::ALU_ADD;
          diaosi_types_pkg::SUBU: alu_op_d = diaosi_types_pkg::ALU_SUB;
          diaosi_types_pkg::AND:  alu_op_d = diaosi_types_pkg::ALU_AND;
          diaosi_types_pkg::OR:   alu_op_d = diaosi_types_pkg::ALU_OR;
          diaosi_types_pkg::XOR:  alu_op_d = diaosi_types_pkg::ALU_XOR;
          diaosi_types_pkg::SLT:  alu_op_d = diaosi_types_pkg::ALU_SLT;
          diaosi_types_pkg::SLL: begin
            alu_op_d  = diaosi_types_pkg::ALU_SLL;
            alu_src_d = diaosi_types_pkg::SHAMT_DIAOSI;
          end
          diaosi_types_pkg::SRL: begin
            alu_op_d  = diaosi_types_pkg::ALU_SRL;
            alu_src_d = diaosi_types_pkg::SHAMT_DIAOSI;
          end
          default: begin
            wen_d   = 1'b0;
            wsel_d  = '0;
            w_mux_d = diaosi_types_pkg::LUI_DIAOSI;
          end
        endcase
      end
      diaosi_types_pkg::ADDIU, diaosi_types_pkg::ANDI, diaosi_types_pkg::ORI: begin
        wen_d     = 1'b1;
        wsel_d    = rt;
        w_mux_d   = diaosi_types_pkg::ALU_DIAOSI;
        alu_src_d = diaosi_types_pkg::EXT32_DIAOSI;
        if (opcode == diaosi_types_pkg::ANDI) begin
          alu_op_d = diaosi_types_pkg::ALU_AND;
        end else if (opcode == diaosi_types_pkg::ORI) begin
          alu_op_d = diaosi_types_pkg::ALU_OR;
        end else begin
          alu_op_d = diaosi_types_pkg::ALU_ADD;
        end
      end
      diaosi_types_pkg::LUI: begin
        wen_d  = 1'b1;
        wsel_d = rt;
      end
      // Loads and stores share the address add.
      diaosi_types_pkg::LW, diaosi_types_pkg::SW: begin
        w_mux_d   = diaosi_types_pkg::ALU_DIAOSI;
        alu_src_d = diaosi_types_pkg::EXT32_DIAOSI;
        alu_op_d  = diaosi_types_pkg::ALU_ADD;
        d_ren_d   = (opcode == diaosi_types_pkg::LW);
        d_wen_d   = (opcode == diaosi_types_pkg::SW);
        wen_d     = (opcode == diaosi_types_pkg::LW);
        wsel_d    = (opcode == diaosi_types_pkg::LW) ? rt : '0;
      end
      diaosi_types_pkg::BEQ, diaosi_types_pkg::BNE: begin
        pc_src_d = diaosi_types_pkg::BRANCH_DIAOSI;
        alu_op_d = diaosi_types_pkg::ALU_SUB;
        if (opcode == diaosi_types_pkg::BNE) begin
          zero_sel_d = diaosi_types_pkg::BNE_DIAOSI;
        end
      end
      diaosi_types_pkg::J: pc_src_d = diaosi_types_pkg::JUMP_DIAOSI;
      diaosi_types_pkg::HALT_OPCODE: halt_d = 1'b1;
      default: ;
    endcase
  end

endmodule

//--- common/diaosi_types_pkg.sv
// Shared definitions for the decode/execute slice.
// Data widths, opcode and funct values, ALU operations and the mux selects.
package diaosi_types_pkg;

  localparam int WORD_W     = 32;
  localparam int REG_ADDR_W = 5;

  // Opcode that stops the core.
  localparam logic [5:0] HALT_OPCODE = 6'h3F;

  // **************************************************
  // Instruction encodings.
  // **************************************************
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ANDI  = 6'h0C,
    ORI   = 6'h0D,
    LUI   = 6'h0F,
    LW    = 6'h23,
    SW    = 6'h2B,
    HALT  = HALT_OPCODE
  } opcode_t;

  typedef enum logic [5:0] {
    SLL  = 6'h00,
    SRL  = 6'h02,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    SLT  = 6'h2A
  } funct_t;

  // **************************************************
  // Control encodings.
  // **************************************************
  typedef enum logic [3:0] {
    ALU_SLL,
    ALU_SRL,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } aluop_t;

  typedef enum logic [1:0] {
    ADD4_DIAOSI,
    BRANCH_DIAOSI,
    JUMP_DIAOSI
  } pcsrc_t;

  typedef enum logic [1:0] {
    RDAT2_DIAOSI,
    EXT32_DIAOSI,
    SHAMT_DIAOSI
  } alusrc_t;

  typedef enum logic {
    LUI_DIAOSI,
    ALU_DIAOSI
  } wmux_t;

  typedef enum logic {
    BEQ_DIAOSI,
    BNE_DIAOSI
  } zerosel_t;

endpackage
